// ==== Makefile ====
# Verilator build and run for the dense-to-sparse converter

VERILATOR  ?= verilator
TOP        ?= sdr_convert_tb
LINT_TOP   ?= sdr_convert_top
FLIST      ?= sdr_convert.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
SEED_ARGS  ?= +verilator+seed+1
BUILD_ARGS ?= --binary --assert -j 0
LINT_ARGS  ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_ARGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_ARGS) -f $(FLIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/sdr_control_fsm.sv ====
/*
 * Control FSM of the dense-to-sparse converter.
 * Sequences the bit scan and the FIFO drain into the index store,
 * and drives the busy, done, FIFO full and overflow status levels.
 */

`timescale 1ns/10ps

module sdr_control_fsm
    import sdr_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic start_i,
    input  logic shift_cnt_dn_i,
    input  logic fifo_rvalid_i,
    input  logic fifo_full_i,
    input  logic idx_cnt_dn_i,
    output logic shift_counter_rst_o,
    output logic shift_counter_en_o,
    output logic fifo_rready_o,
    output logic fifo_clr_o,
    output logic sdr_indexes_counter_rst_o,
    output logic busy_o,
    output logic convert_done_o,
    output logic error_fifo_full_o,
    output logic error_st_o
);

    sdr_state_e state_q;
    sdr_state_e state_d;

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE, SDR_DONE_ST, SDR_ERROR_ST:
            begin
                if (start_i)
                begin
                    state_d = SHIFT_DATA_ST;
                end
            end
            SHIFT_DATA_ST:
            begin
                if (shift_cnt_dn_i)
                begin
                    state_d = SDR_INDEX_ST;
                end
            end
            SDR_INDEX_ST:
            begin
                // Overflow wins over an empty FIFO
                if (idx_cnt_dn_i)
                begin
                    state_d = SDR_ERROR_ST;
                end
                else if (!fifo_rvalid_i)
                begin
                    state_d = SDR_DONE_ST;
                end
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        shift_counter_rst_o       = 1'b0;
        shift_counter_en_o        = 1'b0;
        fifo_rready_o             = 1'b0;
        fifo_clr_o                = 1'b0;
        sdr_indexes_counter_rst_o = 1'b0;
        busy_o                    = 1'b0;
        convert_done_o            = 1'b0;
        error_fifo_full_o         = 1'b0;
        error_st_o                = 1'b0;
        case (state_q)
            SHIFT_DATA_ST:
            begin
                shift_counter_en_o        = !shift_cnt_dn_i;
                sdr_indexes_counter_rst_o = 1'b1;
                busy_o                    = 1'b1;
                error_fifo_full_o         = fifo_full_i;
            end
            SDR_INDEX_ST:
            begin
                fifo_rready_o  = 1'b1;
                busy_o         = 1'b1;
                convert_done_o = !fifo_rvalid_i;
                error_st_o     = idx_cnt_dn_i;
            end
            SDR_DONE_ST, SDR_ERROR_ST:
            begin
                // A new start reloads the vector and clears the result
                if (start_i)
                begin
                    shift_counter_rst_o       = 1'b1;
                    fifo_clr_o                = 1'b1;
                    sdr_indexes_counter_rst_o = 1'b1;
                end
                else
                begin
                    convert_done_o = 1'b1;
                    error_st_o     = (state_q == SDR_ERROR_ST);
                end
            end
            default:
            begin
                shift_counter_rst_o       = 1'b1;
                fifo_clr_o                = 1'b1;
                sdr_indexes_counter_rst_o = 1'b1;
            end
        endcase
    end

endmodule

// ==== rtl/sdr_convert_top.sv ====
/*
 * Dense-to-sparse converter top level.
 * Connects the control FSM, the vector scanner, the index FIFO
 * and the SDR index store.
 */

`timescale 1ns/10ps

module sdr_convert_top
    import sdr_pkg::*;
#(
    parameter int unsigned VEC_W      = DEF_VEC_W,
    parameter int unsigned FIFO_DEPTH = DEF_FIFO_DEPTH,
    parameter int unsigned MAX_ACTIVE = DEF_MAX_ACTIVE
)
(
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            start_i,
    input  logic [VEC_W-1:0]                vector_i,
    input  logic [$clog2(MAX_ACTIVE)-1:0]   rd_addr_i,
    output logic                            busy_o,
    output logic                            done_o,
    output logic                            fifo_full_o,
    output logic                            error_o,
    output logic [$clog2(MAX_ACTIVE+1)-1:0] active_count_o,
    output logic [$clog2(VEC_W)-1:0]        rd_data_o
);

    localparam int unsigned IDX_W = $clog2(VEC_W);

    logic             shift_counter_rst;
    logic             shift_counter_en;
    logic             shift_cnt_dn;
    logic             fifo_clr;
    logic             fifo_rready;
    logic             fifo_rvalid;
    logic             fifo_full;
    logic [IDX_W-1:0] fifo_rdata;
    logic             sdr_indexes_counter_rst;
    logic             idx_cnt_dn;
    logic             push;
    logic [IDX_W-1:0] push_idx;
    logic             scan_fifo_full;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////

    sdr_control_fsm u_fsm
    (
        .clk_i                     (clk_i),
        .rst_ni                    (rst_ni),
        .start_i                   (start_i),
        .shift_cnt_dn_i            (shift_cnt_dn),
        .fifo_rvalid_i             (fifo_rvalid),
        .fifo_full_i               (fifo_full),
        .idx_cnt_dn_i              (idx_cnt_dn),
        .shift_counter_rst_o       (shift_counter_rst),
        .shift_counter_en_o        (shift_counter_en),
        .fifo_rready_o             (fifo_rready),
        .fifo_clr_o                (fifo_clr),
        .sdr_indexes_counter_rst_o (sdr_indexes_counter_rst),
        .busy_o                    (busy_o),
        .convert_done_o            (done_o),
        .error_fifo_full_o         (scan_fifo_full),
        .error_st_o                (error_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    sdr_shift_unit #(.VEC_W(VEC_W)) u_shift
    (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .vector_i   (vector_i),
        .load_i     (shift_counter_rst),
        .en_i       (shift_counter_en),
        .push_o     (push),
        .push_idx_o (push_idx),
        .cnt_dn_o   (shift_cnt_dn)
    );

    sdr_index_fifo #(.VEC_W(VEC_W), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo
    (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .clr_i    (fifo_clr),
        .push_i   (push),
        .wdata_i  (push_idx),
        .rready_i (fifo_rready),
        .rvalid_o (fifo_rvalid),
        .rdata_o  (fifo_rdata),
        .full_o   (fifo_full)
    );

    sdr_index_store #(.VEC_W(VEC_W), .MAX_ACTIVE(MAX_ACTIVE)) u_store
    (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clr_i      (sdr_indexes_counter_rst),
        .wr_i       (fifo_rready && fifo_rvalid),
        .wdata_i    (fifo_rdata),
        .rd_addr_i  (rd_addr_i),
        .count_o    (active_count_o),
        .rd_data_o  (rd_data_o),
        .overflow_o (idx_cnt_dn)
    );

    // Full flag is only reported while the scan is running
    assign fifo_full_o = scan_fifo_full;

endmodule

// ==== rtl/sdr_index_fifo.sv ====
/*
 * Set-bit index FIFO.
 * Circular buffer with synchronous clear; pushes while full are
 * dropped and the oldest entry is shown whenever rvalid is high.
 */

`timescale 1ns/10ps

module sdr_index_fifo
    import sdr_pkg::*;
#(
    parameter int unsigned VEC_W      = DEF_VEC_W,
    parameter int unsigned FIFO_DEPTH = DEF_FIFO_DEPTH
)
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     clr_i,
    input  logic                     push_i,
    input  logic [$clog2(VEC_W)-1:0] wdata_i,
    input  logic                     rready_i,
    output logic                     rvalid_o,
    output logic [$clog2(VEC_W)-1:0] rdata_o,
    output logic                     full_o
);

    localparam int unsigned DATA_W = $clog2(VEC_W);
    localparam int unsigned PTR_W  = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W  = $clog2(FIFO_DEPTH + 1);

    logic [DATA_W-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]  wptr_q;
    logic [PTR_W-1:0]  rptr_q;
    logic [CNT_W-1:0]  fill_q;
    logic              wr_en;
    logic              rd_en;

    assign full_o   = (fill_q == CNT_W'(FIFO_DEPTH));
    assign rvalid_o = (fill_q != '0);
    assign wr_en    = push_i && !full_o;
    assign rd_en    = rready_i && rvalid_o;
    assign rdata_o  = mem_q[rptr_q];

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and fill count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            wptr_q <= '0;
            rptr_q <= '0;
            fill_q <= '0;
        end
        else if (clr_i)
        begin
            wptr_q <= '0;
            rptr_q <= '0;
            fill_q <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wptr_q <= (wptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wptr_q + PTR_W'(1);
            end
            if (rd_en)
            begin
                rptr_q <= (rptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rptr_q + PTR_W'(1);
            end
            if (wr_en && !rd_en)
            begin
                fill_q <= fill_q + CNT_W'(1);
            end
            else if (rd_en && !wr_en)
            begin
                fill_q <= fill_q - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_en)
        begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

endmodule

// ==== rtl/sdr_index_store.sv ====
/*
 * SDR index store.
 * Appends each popped index at the active count, flags a write
 * beyond capacity as overflow and serves the host read port.
 */

`timescale 1ns/10ps

module sdr_index_store
    import sdr_pkg::*;
#(
    parameter int unsigned VEC_W      = DEF_VEC_W,
    parameter int unsigned MAX_ACTIVE = DEF_MAX_ACTIVE
)
(
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            clr_i,
    input  logic                            wr_i,
    input  logic [$clog2(VEC_W)-1:0]        wdata_i,
    input  logic [$clog2(MAX_ACTIVE)-1:0]   rd_addr_i,
    output logic [$clog2(MAX_ACTIVE+1)-1:0] count_o,
    output logic [$clog2(VEC_W)-1:0]        rd_data_o,
    output logic                            overflow_o
);

    localparam int unsigned DATA_W = $clog2(VEC_W);
    localparam int unsigned ADDR_W = $clog2(MAX_ACTIVE);
    localparam int unsigned CNT_W  = $clog2(MAX_ACTIVE + 1);

    logic [DATA_W-1:0] mem_q [MAX_ACTIVE];
    logic [CNT_W-1:0]  count_q;
    logic              store_full;

    assign store_full = (count_q == CNT_W'(MAX_ACTIVE));
    assign count_o    = count_q;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            count_q    <= '0;
            overflow_o <= 1'b0;
        end
        else if (clr_i)
        begin
            count_q    <= '0;
            overflow_o <= 1'b0;
        end
        else if (wr_i)
        begin
            if (store_full)
            begin
                overflow_o <= 1'b1;
            end
            else
            begin
                count_q <= count_q + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_i && !store_full)
        begin
            mem_q[count_q[ADDR_W-1:0]] <= wdata_i;
        end
    end

    // Addresses past the capacity read as zero
    assign rd_data_o = (rd_addr_i < ADDR_W'(MAX_ACTIVE - 1) + ADDR_W'(1) || MAX_ACTIVE == 2**ADDR_W)
                     ? mem_q[rd_addr_i] : '0;

endmodule

// ==== rtl/sdr_pkg.sv ====
/*
 * Dense-to-sparse converter shared definitions.
 * Holds the control FSM state encoding and the default sizes
 * used by every block of the converter.
 */

package sdr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        IDLE,
        SHIFT_DATA_ST,
        SDR_INDEX_ST,
        SDR_DONE_ST,
        SDR_ERROR_ST
    } sdr_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Default sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned DEF_VEC_W      = 32;
    localparam int unsigned DEF_FIFO_DEPTH = 16;
    localparam int unsigned DEF_MAX_ACTIVE = 8;

endpackage

// ==== rtl/sdr_shift_unit.sv ====
/*
 * Dense vector scanner.
 * Shifts the loaded vector right one bit per enabled cycle and
 * pushes the position of every set bit towards the index FIFO.
 */

`timescale 1ns/10ps

module sdr_shift_unit
    import sdr_pkg::*;
#(
    parameter int unsigned VEC_W = DEF_VEC_W
)
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [VEC_W-1:0]         vector_i,
    input  logic                     load_i,
    input  logic                     en_i,
    output logic                     push_o,
    output logic [$clog2(VEC_W)-1:0] push_idx_o,
    output logic                     cnt_dn_o
);

    localparam int unsigned IDX_W = $clog2(VEC_W);
    // Wide enough to hold VEC_W itself
    localparam int unsigned CNT_W = $clog2(VEC_W + 1);

    logic [VEC_W-1:0] shift_q;
    logic [CNT_W-1:0] pos_q;
    logic             step;

    assign cnt_dn_o = (pos_q == CNT_W'(VEC_W));
    assign step     = en_i && !cnt_dn_o;

    ////////////////////////////////////////////////////////////////////////////
    // Position counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            pos_q <= '0;
        end
        else if (load_i)
        begin
            pos_q <= '0;
        end
        else if (step)
        begin
            pos_q <= pos_q + CNT_W'(1);
        end
    end

    // Vector register
    always_ff @(posedge clk_i)
    begin
        if (load_i)
        begin
            shift_q <= vector_i;
        end
        else if (step)
        begin
            shift_q <= shift_q >> 1;
        end
    end

    assign push_o     = step && shift_q[0];
    assign push_idx_o = pos_q[IDX_W-1:0];

endmodule

// ==== sdr_convert.f ====
rtl/sdr_pkg.sv
rtl/sdr_control_fsm.sv
rtl/sdr_shift_unit.sv
rtl/sdr_index_fifo.sv
rtl/sdr_index_store.sv
rtl/sdr_convert_top.sv
tb/sdr_convert_tb.sv

// ==== tb/sdr_convert_tb.sv ====
/*
 * Testbench for the dense-to-sparse converter.
 * Runs directed and random dense vectors through the converter and
 * checks timing, status levels and the stored SDR against a model.
 */

`timescale 1ns/10ps

module sdr_convert_tb
    import sdr_pkg::*;
;

    localparam int unsigned VEC_W       = DEF_VEC_W;
    localparam int unsigned FIFO_DEPTH  = DEF_FIFO_DEPTH;
    localparam int unsigned MAX_ACTIVE  = DEF_MAX_ACTIVE;
    localparam int unsigned IDX_W       = $clog2(VEC_W);
    localparam int unsigned ADDR_W      = $clog2(MAX_ACTIVE);
    localparam int unsigned CNT_W       = $clog2(MAX_ACTIVE + 1);
    localparam int unsigned CLK_PERIOD  = 40;
    localparam int unsigned DONE_LIMIT  = VEC_W + FIFO_DEPTH + 10;
    localparam int unsigned WATCHDOG_NS = 60 * DONE_LIMIT * CLK_PERIOD;
    localparam int unsigned N_RANDOM    = 40;
    localparam logic [31:0] SEED        = 32'hef5a_dc68;

    logic              clk_i;
    logic              rst_ni;
    logic              start_i;
    logic [VEC_W-1:0]  vector_i;
    logic [ADDR_W-1:0] rd_addr_i;
    logic              busy_o;
    logic              done_o;
    logic              fifo_full_o;
    logic              error_o;
    logic [CNT_W-1:0]  active_count_o;
    logic [IDX_W-1:0]  rd_data_o;

    // Reference model state for the current vector
    int exp_list [FIFO_DEPTH];
    int exp_q;
    int exp_pop;
    int cur_pop = 0;

    int value_errors = 0;
    int other_errors = 0;

    sdr_convert_top #(
        .VEC_W      (VEC_W),
        .FIFO_DEPTH (FIFO_DEPTH),
        .MAX_ACTIVE (MAX_ACTIVE)
    ) dut0
    (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .start_i        (start_i),
        .vector_i       (vector_i),
        .rd_addr_i      (rd_addr_i),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .fifo_full_o    (fifo_full_o),
        .error_o        (error_o),
        .active_count_o (active_count_o),
        .rd_data_o      (rd_data_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // Concurrent checks
    ////////////////////////////////////////////////////////////////////////////

    full_only_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!fifo_full_o || busy_o))
    else
    begin
        value_errors++;
        $display("[ERROR] %0t fifo_full_o outside busy expected 0 got 1", $time);
    end

    full_only_dense: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!fifo_full_o || cur_pop >= FIFO_DEPTH))
    else
    begin
        value_errors++;
        $display("[ERROR] %0t fifo_full_o with %0d set bits expected 0 got 1",
                 $time, cur_pop);
    end

    count_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (active_count_o <= CNT_W'(MAX_ACTIVE)))
    else
    begin
        value_errors++;
        $display("[ERROR] %0t active_count_o expected <= %0d got %0d",
                 $time, MAX_ACTIVE, active_count_o);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input longint exp_val, input longint act_val);
        assert (exp_val == act_val)
        else
        begin
            value_errors++;
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp_val, act_val);
        end
    endtask

    // Ascending set-bit indices, cut at the FIFO depth
    function automatic void build_reference(input logic [VEC_W-1:0] vec);
        int b;
        exp_pop = 0;
        exp_q   = 0;
        for (b = 0; b < VEC_W; b++)
        begin
            if (vec[b])
            begin
                exp_pop++;
                if (exp_q < FIFO_DEPTH)
                begin
                    exp_list[exp_q] = b;
                    exp_q++;
                end
            end
        end
    endfunction

    function automatic logic [VEC_W-1:0] random_vector(input int unsigned percent);
        logic [VEC_W-1:0] v;
        int               b;
        v = '0;
        for (b = 0; b < VEC_W; b++)
        begin
            v[b] = ($urandom_range(99) < percent);
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // One conversion
    ////////////////////////////////////////////////////////////////////////////

    // poke_cycle > 0 sends an extra start pulse that many cycles into busy
    task automatic convert_vector(input logic [VEC_W-1:0] vec, input int poke_cycle);
        int         n;
        int         i;
        int         low_cycles;
        int         exp_low;
        int         exp_count;
        bit         exp_err;
        bit         seen_full;
        bit         finished;
        sdr_state_e exp_state;
        build_reference(vec);
        exp_err   = (exp_q > MAX_ACTIVE);
        exp_count = exp_err ? MAX_ACTIVE : exp_q;
        exp_state = exp_err ? SDR_ERROR_ST : SDR_DONE_ST;
        cur_pop   = exp_pop;
        if (exp_err)
        begin
            // Overflowing pop, then one more cycle while the FIFO still holds entries
            exp_low = VEC_W + 1 + MAX_ACTIVE + 1 + ((exp_q > MAX_ACTIVE + 1) ? 1 : 0);
        end
        else
        begin
            exp_low = VEC_W + 1 + exp_q;
        end

        @(posedge clk_i);
        start_i  <= 1'b1;
        vector_i <= vec;
        @(negedge clk_i);
        check_value("done_o", 0, done_o);
        check_value("error_o", 0, error_o);
        @(posedge clk_i);
        start_i  <= 1'b0;
        vector_i <= ~vec;

        n          = 0;
        low_cycles = 0;
        seen_full  = 1'b0;
        finished   = 1'b0;
        while (!finished)
        begin
            @(negedge clk_i);
            n++;
            if (fifo_full_o)
            begin
                seen_full = 1'b1;
            end
            if (n <= VEC_W + 1)
            begin
                check_value("busy_o", 1, busy_o);
                check_value("done_o", 0, done_o);
            end
            if (!exp_err)
            begin
                check_value("error_o", 0, error_o);
            end
            if (done_o)
            begin
                finished = 1'b1;
            end
            else if (n > DONE_LIMIT)
            begin
                other_errors++;
                $display("Conversion did not reach %s within %0d cycles",
                         exp_state.name(), DONE_LIMIT);
                finished = 1'b1;
            end
            else
            begin
                low_cycles++;
                @(posedge clk_i);
                start_i <= (n == poke_cycle);
            end
        end

        check_value("done_o low cycles", exp_low, low_cycles);
        if (exp_pop > FIFO_DEPTH)
        begin
            check_value("fifo_full_o seen", 1, seen_full);
        end

        // Settled in the done or error state
        @(negedge clk_i);
        check_value("busy_o", 0, busy_o);
        check_value("done_o", 1, done_o);
        check_value("error_o", exp_err, error_o);
        check_value("active_count_o", exp_count, active_count_o);

        for (i = 0; i < exp_count; i++)
        begin
            @(posedge clk_i);
            rd_addr_i <= ADDR_W'(i);
            @(negedge clk_i);
            check_value($sformatf("rd_data_o[%0d]", i), exp_list[i], rd_data_o);
            check_value("done_o", 1, done_o);
            check_value("error_o", exp_err, error_o);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int k;
        int unsigned density [7];
        density  = '{3, 10, 20, 30, 50, 75, 95};
        void'($urandom(SEED));
        rst_ni    = 1'b0;
        start_i   = 1'b0;
        vector_i  = '0;
        rd_addr_i = '0;

        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("busy_o", 0, busy_o);
        check_value("done_o", 0, done_o);
        check_value("error_o", 0, error_o);
        check_value("fifo_full_o", 0, fifo_full_o);
        check_value("active_count_o", 0, active_count_o);

        convert_vector(32'h0000_0000, 0);
        convert_vector(32'h8010_0405, 3);
        convert_vector(32'h1111_1111, 0);
        convert_vector(32'h9111_1111, 0);
        convert_vector(32'h5555_5555, 0);
        // Extra start lands in the index phase here
        convert_vector(32'hffff_ffff, VEC_W + 3);

        for (k = 0; k < N_RANDOM; k++)
        begin
            convert_vector(random_vector(density[k % 7]), 0);
        end

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all conversions finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
